// File: rtl/decoder_ctrl_pkg.sv
`default_nettype none

package decoder_ctrl_pkg;

    // grid geometry and timing
    localparam int grid_x = 4;
    localparam int grid_u = 3;
    localparam int maximum_delay = 3;
    localparam int fifo_depth = 8;

    // 3 north-south, 4 east-west and 4 up-down bits per round
    localparam int correction_bits = 11;
    localparam int correction_padded = 16;

    typedef enum logic [2:0] {
        stage_idle,
        stage_load,
        stage_grow,
        stage_merge,
        stage_peel,
        stage_readout
    } stage_t;

    typedef logic [1:0] round_t;
    typedef logic [grid_x-1:0] pe_vec_t;
    typedef logic [correction_bits-1:0] correction_t;
    typedef logic [15:0] cycle_count_t;
    typedef logic [7:0] iter_count_t;
    typedef logic [31:0] stream_word_t;

    // control message codes
    localparam logic [7:0] header_decode_block = 8'h02;
    localparam logic [7:0] header_result = 8'h03;
    localparam stream_word_t end_marker = 32'hffff_ffff;

    // payload bit 0 is peel_and_finish, result carries cycles in 15:0
    typedef struct packed {
        logic [7:0] header;
        logic [7:0] dest;
        logic [47:0] payload;
    } ctrl_msg_t;

    typedef struct packed {
        logic valid;
        round_t round;
        pe_vec_t defects;
    } measurement_t;

    typedef struct packed {
        logic valid;
        round_t round;
    } readout_req_t;

    // counts is {iterations, cycles}
    typedef struct packed {
        logic is_header;
        logic [23:0] counts;
        correction_t correction;
    } fifo_word_t;

endpackage

`default_nettype wire

// File: rtl/stage_controller.sv
`timescale 1ns/1ns
`default_nettype none

module stage_controller (
    input  wire clk,
    input  wire reset,
    input  wire decoder_ctrl_pkg::ctrl_msg_t ctrl_rx,
    input  wire ctrl_rx_valid,
    output logic ctrl_rx_ready,
    input  wire load_done,
    input  wire decoder_ctrl_pkg::pe_vec_t busy_pe,
    input  wire decoder_ctrl_pkg::pe_vec_t odd_clusters_pe,
    input  wire decoder_ctrl_pkg::correction_t correction,
    input  wire decoder_ctrl_pkg::cycle_count_t cycle_count,
    input  wire decoder_ctrl_pkg::iter_count_t iter_count,
    output decoder_ctrl_pkg::stage_t stage,
    output decoder_ctrl_pkg::readout_req_t readout_req,
    output decoder_ctrl_pkg::fifo_word_t fifo_wr,
    output logic fifo_wr_valid
);
    import decoder_ctrl_pkg::*;

    logic [$clog2(maximum_delay+1)-1:0] delay_cnt;
    logic peel_flag;
    logic busy;
    logic odd_clusters;
    round_t rd_round;
    logic was_readout;

    // one level of reduction per PE vector
    always_ff @(posedge clk) begin
        busy <= |busy_pe;
        odd_clusters <= |odd_clusters_pe;
    end

    assign ctrl_rx_ready = (stage == stage_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            stage <= stage_idle;
            delay_cnt <= '0;
            peel_flag <= 1'b0;
            rd_round <= '0;
            was_readout <= 1'b0;
        end else begin
            was_readout <= (stage == stage_readout);
            case (stage)
                stage_idle: begin
                    // other headers are consumed and dropped
                    if (ctrl_rx_valid && ctrl_rx_ready &&
                            ctrl_rx.header == header_decode_block) begin
                        stage <= stage_load;
                        peel_flag <= ctrl_rx.payload[0];
                    end
                end
                stage_load: begin
                    if (load_done) begin
                        stage <= stage_grow;
                    end
                end
                stage_grow: begin
                    stage <= stage_merge;
                    delay_cnt <= '0;
                end
                stage_merge: begin
                    // busy is not trusted until the array had time to settle
                    if (delay_cnt != $bits(delay_cnt)'(maximum_delay)) begin
                        delay_cnt <= delay_cnt + 1;
                    end else if (!busy) begin
                        if (odd_clusters) begin
                            stage <= stage_grow;
                        end else if (peel_flag) begin
                            stage <= stage_peel;
                        end else begin
                            stage <= stage_idle;
                        end
                    end
                end
                stage_peel: begin
                    stage <= stage_readout;
                    rd_round <= '0;
                end
                stage_readout: begin
                    if (rd_round == round_t'(grid_u - 1)) begin
                        stage <= stage_idle;
                    end else begin
                        rd_round <= rd_round + 1;
                    end
                end
                default: stage <= stage_idle;
            endcase
        end
    end

    assign readout_req.valid = (stage == stage_readout);
    assign readout_req.round = rd_round;

    // header on the first readout cycle, then the answer to each request
    assign fifo_wr_valid = (stage == stage_readout) || was_readout;
    assign fifo_wr.is_header = !was_readout;
    assign fifo_wr.counts = {iter_count, cycle_count};
    assign fifo_wr.correction = correction;

    a_fifo_wr_only_with_peel: assert property (@(posedge clk) disable iff (reset)
        fifo_wr_valid |-> peel_flag);

endmodule

`default_nettype wire

// File: rtl/measurement_loader.sv
`timescale 1ns/1ns
`default_nettype none

module measurement_loader (
    input  wire clk,
    input  wire reset,
    input  wire decoder_ctrl_pkg::stage_t stage,
    input  wire decoder_ctrl_pkg::stream_word_t in_data,
    input  wire in_valid,
    output logic in_ready,
    output decoder_ctrl_pkg::measurement_t measurements,
    output logic load_done
);
    import decoder_ctrl_pkg::*;

    round_t cur_round;
    pe_vec_t defects;
    logic is_end;
    logic last_round;

    assign is_end = (in_data == end_marker);
    assign last_round = (cur_round == round_t'(grid_u - 1));

    // only the end marker after the last round and words of this round are taken
    assign in_ready = (stage == stage_load) && !load_done && in_valid &&
                      (is_end ? last_round : (in_data[3:2] == cur_round));

    always_ff @(posedge clk) begin
        if (reset) begin
            cur_round <= '0;
            load_done <= 1'b0;
            measurements <= '0;
        end else begin
            load_done <= 1'b0;
            measurements.valid <= 1'b0;
            if (stage != stage_load) begin
                cur_round <= '0;
                defects <= '0;
            end else if (in_valid && !load_done) begin
                if (in_ready && !is_end) begin
                    defects[in_data[1:0]] <= 1'b1;
                end else begin
                    // round closed, show it to the array for one cycle
                    measurements.valid <= 1'b1;
                    measurements.round <= cur_round;
                    measurements.defects <= defects;
                    defects <= '0;
                    if (is_end && last_round) begin
                        load_done <= 1'b1;
                        cur_round <= '0;
                    end else begin
                        cur_round <= cur_round + 1;
                    end
                end
            end
        end
    end

    a_load_done_in_load: assert property (@(posedge clk) disable iff (reset)
        load_done |-> stage == stage_load);

endmodule

`default_nettype wire

// File: rtl/latency_counters.sv
`timescale 1ns/1ns
`default_nettype none

module latency_counters (
    input  wire clk,
    input  wire reset,
    input  wire decoder_ctrl_pkg::stage_t stage,
    output decoder_ctrl_pkg::cycle_count_t cycle_count,
    output decoder_ctrl_pkg::iter_count_t iter_count,
    output decoder_ctrl_pkg::ctrl_msg_t ctrl_tx,
    output logic ctrl_tx_valid,
    input  wire ctrl_tx_ready
);
    import decoder_ctrl_pkg::*;

    stage_t prev_stage;

    always_ff @(posedge clk) begin
        if (reset) begin
            prev_stage <= stage_idle;
            cycle_count <= '0;
            iter_count <= '0;
            ctrl_tx_valid <= 1'b0;
        end else begin
            prev_stage <= stage;
            // starting at 1 makes the count show the current cycle
            if (stage == stage_load && prev_stage != stage_load) begin
                cycle_count <= 16'd1;
            end else if (stage == stage_grow || stage == stage_merge ||
                         stage == stage_peel) begin
                cycle_count <= cycle_count + 1;
            end
            if (stage == stage_load) begin
                iter_count <= '0;
            end else if (stage == stage_grow && prev_stage != stage_grow) begin
                iter_count <= iter_count + 1;
            end
            if (stage == stage_readout && prev_stage != stage_readout) begin
                ctrl_tx_valid <= 1'b1;
                ctrl_tx.header <= header_result;
                ctrl_tx.dest <= 8'h00;
                ctrl_tx.payload <= {32'h0, cycle_count};
            end else if (ctrl_tx_ready) begin
                ctrl_tx_valid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/correction_fifo.sv
`timescale 1ns/1ns
`default_nettype none

module correction_fifo (
    input  wire clk,
    input  wire reset,
    input  wire decoder_ctrl_pkg::fifo_word_t wr_data,
    input  wire wr_valid,
    output logic wr_ready,
    output decoder_ctrl_pkg::fifo_word_t rd_data,
    output logic rd_valid,
    input  wire rd_ready
);
    import decoder_ctrl_pkg::*;

    fifo_word_t mem [fifo_depth];
    logic [$clog2(fifo_depth)-1:0] wr_ptr;
    logic [$clog2(fifo_depth)-1:0] rd_ptr;
    logic [$clog2(fifo_depth+1)-1:0] count;
    logic push;
    logic pop;

    assign wr_ready = (count != $bits(count)'(fifo_depth));
    assign rd_valid = (count != '0);
    assign rd_data = mem[rd_ptr];

    assign push = wr_valid && wr_ready;
    assign pop = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // pointers wrap on their own with a power of two depth
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1;
            end
            if (push && !pop) begin
                count <= count + 1;
            end else if (pop && !push) begin
                count <= count - 1;
            end
        end
    end

    a_no_write_when_full: assert property (@(posedge clk) disable iff (reset)
        wr_valid |-> wr_ready);

endmodule

`default_nettype wire

// File: rtl/correction_serializer.sv
`timescale 1ns/1ns
`default_nettype none

module correction_serializer (
    input  wire clk,
    input  wire reset,
    input  wire decoder_ctrl_pkg::fifo_word_t rd_data,
    input  wire rd_valid,
    output logic rd_ready,
    output decoder_ctrl_pkg::stream_word_t out_data,
    output logic out_valid,
    input  wire out_ready
);
    import decoder_ctrl_pkg::*;

    typedef enum logic [1:0] {
        ph_header,
        ph_round,
        ph_end
    } phase_t;

    phase_t phase;
    round_t ser_round;
    logic loaded;
    logic [correction_padded-1:0] work;
    logic [correction_padded-1:0] work_rest;
    logic round_done;

    function automatic logic [3:0] lowest_bit(input logic [correction_padded-1:0] v);
        logic [3:0] idx;
        idx = '0;
        for (int i = correction_padded - 1; i >= 0; i--) begin
            if (v[i]) begin
                idx = i[3:0];
            end
        end
        return idx;
    endfunction

    // working copy minus its lowest set bit
    assign work_rest = work & (work - 1);

    assign round_done = (phase == ph_round) &&
                        ((!loaded && rd_valid && rd_data.correction == '0) ||
                         (loaded && out_ready && work_rest == '0));

    always_comb begin
        out_data = end_marker;
        out_valid = 1'b0;
        rd_ready = 1'b0;
        case (phase)
            ph_header: begin
                out_data = {8'h00, rd_data.counts};
                out_valid = rd_valid && rd_data.is_header;
                // a stray correction word ahead of a header is dropped
                rd_ready = rd_valid && (out_ready || !rd_data.is_header);
            end
            ph_round: begin
                out_data = {25'h0, 1'b0, ser_round, lowest_bit(work)};
                out_valid = loaded;
                rd_ready = !loaded;
            end
            default: begin
                out_valid = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= ph_header;
            ser_round <= '0;
            loaded <= 1'b0;
        end else begin
            case (phase)
                ph_header: begin
                    if (rd_valid && rd_data.is_header && out_ready) begin
                        phase <= ph_round;
                        ser_round <= '0;
                    end
                end
                ph_round: begin
                    if (!loaded && rd_valid && rd_data.correction != '0) begin
                        loaded <= 1'b1;
                    end else if (round_done) begin
                        loaded <= 1'b0;
                    end
                    if (round_done) begin
                        if (ser_round == round_t'(grid_u - 1)) begin
                            phase <= ph_end;
                        end else begin
                            ser_round <= ser_round + 1;
                        end
                    end
                end
                default: begin
                    if (out_ready) begin
                        phase <= ph_header;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == ph_round && rd_ready && rd_valid) begin
            work <= {{(correction_padded - correction_bits){1'b0}}, rd_data.correction};
        end else if (phase == ph_round && out_valid && out_ready) begin
            work <= work_rest;
        end
    end

endmodule

`default_nettype wire

// File: rtl/decoder_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module decoder_ctrl_top (
    input  wire clk,
    input  wire reset,
    input  wire decoder_ctrl_pkg::ctrl_msg_t ctrl_rx,
    input  wire ctrl_rx_valid,
    output logic ctrl_rx_ready,
    output decoder_ctrl_pkg::ctrl_msg_t ctrl_tx,
    output logic ctrl_tx_valid,
    input  wire ctrl_tx_ready,
    input  wire decoder_ctrl_pkg::stream_word_t in_data,
    input  wire in_valid,
    output logic in_ready,
    output decoder_ctrl_pkg::stream_word_t out_data,
    output logic out_valid,
    input  wire out_ready,
    input  wire decoder_ctrl_pkg::pe_vec_t busy_pe,
    input  wire decoder_ctrl_pkg::pe_vec_t odd_clusters_pe,
    input  wire decoder_ctrl_pkg::correction_t correction,
    output decoder_ctrl_pkg::measurement_t measurements,
    output decoder_ctrl_pkg::readout_req_t readout_req,
    output decoder_ctrl_pkg::stage_t stage
);
    import decoder_ctrl_pkg::*;

    logic load_done;
    cycle_count_t cycle_count;
    iter_count_t iter_count;
    fifo_word_t fifo_wr;
    logic fifo_wr_valid;
    fifo_word_t fifo_rd;
    logic fifo_rd_valid;
    logic fifo_rd_ready;

    stage_controller u_stage_controller (
        .clk(clk),
        .reset(reset),
        .ctrl_rx(ctrl_rx),
        .ctrl_rx_valid(ctrl_rx_valid),
        .ctrl_rx_ready(ctrl_rx_ready),
        .load_done(load_done),
        .busy_pe(busy_pe),
        .odd_clusters_pe(odd_clusters_pe),
        .correction(correction),
        .cycle_count(cycle_count),
        .iter_count(iter_count),
        .stage(stage),
        .readout_req(readout_req),
        .fifo_wr(fifo_wr),
        .fifo_wr_valid(fifo_wr_valid)
    );

    measurement_loader u_measurement_loader (
        .clk(clk),
        .reset(reset),
        .stage(stage),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .measurements(measurements),
        .load_done(load_done)
    );

    latency_counters u_latency_counters (
        .clk(clk),
        .reset(reset),
        .stage(stage),
        .cycle_count(cycle_count),
        .iter_count(iter_count),
        .ctrl_tx(ctrl_tx),
        .ctrl_tx_valid(ctrl_tx_valid),
        .ctrl_tx_ready(ctrl_tx_ready)
    );

    // sized for one decode, so the write side never waits
    correction_fifo u_correction_fifo (
        .clk(clk),
        .reset(reset),
        .wr_data(fifo_wr),
        .wr_valid(fifo_wr_valid),
        .wr_ready(),
        .rd_data(fifo_rd),
        .rd_valid(fifo_rd_valid),
        .rd_ready(fifo_rd_ready)
    );

    correction_serializer u_correction_serializer (
        .clk(clk),
        .reset(reset),
        .rd_data(fifo_rd),
        .rd_valid(fifo_rd_valid),
        .rd_ready(fifo_rd_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready)
    );

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic reset
);
    localparam int half_period = 50;
    localparam int reset_cycles = 16;

    initial begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// File: testbench/tb_decoder_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_decoder_ctrl;
    import decoder_ctrl_pkg::*;

    localparam int num_rows = 5;
    localparam int cycles_per_row = 400;

    // defects are {round, x} nibbles, lowest nibble first
    typedef struct packed {
        logic [2:0] defect_count;
        logic [5:0][3:0] defect_list;
        iter_count_t odd_merges;
        logic peel;
        correction_t [grid_u-1:0] corr;
    } row_t;

    logic clk;
    logic reset;
    ctrl_msg_t ctrl_rx;
    logic ctrl_rx_valid;
    logic ctrl_rx_ready;
    ctrl_msg_t ctrl_tx;
    logic ctrl_tx_valid;
    logic ctrl_tx_ready = 1'b0;
    stream_word_t in_data;
    logic in_valid;
    logic in_ready;
    stream_word_t out_data;
    logic out_valid;
    logic out_ready = 1'b0;
    pe_vec_t busy_pe = '0;
    pe_vec_t odd_clusters_pe = '0;
    correction_t correction = '0;
    measurement_t measurements;
    readout_req_t readout_req;
    stage_t stage;

    row_t rows [num_rows];
    row_t cur_row;
    integer seed = 58687;
    int mon_errors = 0;
    int seq_errors = 0;
    iter_count_t grows = '0;

    // output monitor state
    int meas_count = 0;
    logic header_seen = 1'b0;
    logic end_seen = 1'b0;
    logic ctrl_seen = 1'b0;
    logic [23:0] header_counts = '0;
    cycle_count_t ctrl_cycles = '0;
    stream_word_t expected_words [$];
    logic out_stalled = 1'b0;
    stream_word_t stalled_word = '0;
    logic ctrl_stalled = 1'b0;

    tb_clock_gen clock_gen (
        .clk(clk),
        .reset(reset)
    );

    decoder_ctrl_top DUT (
        .clk(clk),
        .reset(reset),
        .ctrl_rx(ctrl_rx),
        .ctrl_rx_valid(ctrl_rx_valid),
        .ctrl_rx_ready(ctrl_rx_ready),
        .ctrl_tx(ctrl_tx),
        .ctrl_tx_valid(ctrl_tx_valid),
        .ctrl_tx_ready(ctrl_tx_ready),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_ready(in_ready),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_ready(out_ready),
        .busy_pe(busy_pe),
        .odd_clusters_pe(odd_clusters_pe),
        .correction(correction),
        .measurements(measurements),
        .readout_req(readout_req),
        .stage(stage)
    );

    function automatic pe_vec_t round_defects(input row_t row, input int r);
        pe_vec_t v;
        v = '0;
        for (int i = 0; i < int'(row.defect_count); i++) begin
            if (int'(row.defect_list[i][3:2]) == r) begin
                v[row.defect_list[i][1:0]] = 1'b1;
            end
        end
        return v;
    endfunction

    // PE array: odd for the first odd_merges merges, busy for one cycle after grow
    always @(posedge clk) begin
        if (reset || stage == stage_load) begin
            grows <= '0;
            busy_pe <= '0;
            odd_clusters_pe <= '0;
            correction <= '0;
        end else begin
            busy_pe <= '0;
            if (stage == stage_grow) begin
                grows <= grows + 8'd1;
                busy_pe <= 4'b0110;
                odd_clusters_pe <= (grows < cur_row.odd_merges) ? 4'b0001 : 4'b0000;
            end
            if (readout_req.valid) begin
                correction <= cur_row.corr[readout_req.round];
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            out_ready <= ($random(seed) & 3) != 0;
            ctrl_tx_ready <= ($random(seed) & 1) != 0;
        end
    end

    always @(negedge clk) begin
        if (!reset) begin
            if (ctrl_rx_valid && ctrl_rx_ready && ctrl_rx.header == header_decode_block) begin
                meas_count = 0;
                header_seen = 1'b0;
                end_seen = 1'b0;
                ctrl_seen = 1'b0;
                expected_words.delete();
                for (int r = 0; r < grid_u; r++) begin
                    for (int b = 0; b < correction_bits; b++) begin
                        if (cur_row.corr[r][b]) begin
                            expected_words.push_back(32'(r * 16 + b));
                        end
                    end
                end
                expected_words.push_back(end_marker);
            end
            if (measurements.valid) begin
                assert (int'(measurements.round) == meas_count &&
                        measurements.defects == round_defects(cur_row, meas_count)) else begin
                    $display("CHECK FAILED at %0t ns: measurement round %0d defects %b, %s %0d",
                             $time, measurements.round, measurements.defects,
                             "expected round", meas_count);
                    mon_errors++;
                end
                meas_count++;
            end
            assert (cur_row.peel || !(out_valid || ctrl_tx_valid)) else begin
                $display("ERROR at %0t ns: output activity in a decode without peel", $time);
                mon_errors++;
            end
            if (out_valid && out_ready && !header_seen) begin
                header_seen = 1'b1;
                header_counts = out_data[23:0];
                assert (out_data[31:24] == 8'h00 && out_data[15:0] != 16'd0 &&
                        out_data[23:16] == cur_row.odd_merges + 8'd1) else begin
                    $display("CHECK FAILED at %0t ns: header word %h, expected iterations %0d",
                             $time, out_data, cur_row.odd_merges + 8'd1);
                    mon_errors++;
                end
            end else if (out_valid && out_ready) begin
                assert (expected_words.size() != 0) else begin
                    $display("ERROR at %0t ns: data word %h after the end marker", $time, out_data);
                    mon_errors++;
                end
                if (expected_words.size() != 0) begin
                    assert (out_data == expected_words[0]) else begin
                        $display("CHECK FAILED at %0t ns: data word %h, expected %h",
                                 $time, out_data, expected_words[0]);
                        mon_errors++;
                    end
                    void'(expected_words.pop_front());
                    end_seen = (expected_words.size() == 0);
                end
            end
            if (ctrl_tx_valid && ctrl_tx_ready) begin
                assert (!ctrl_seen) else begin
                    $display("ERROR at %0t ns: result message sent twice in one decode", $time);
                    mon_errors++;
                end
                ctrl_seen = 1'b1;
                ctrl_cycles = ctrl_tx.payload[15:0];
                assert (ctrl_tx.header == header_result && ctrl_tx.dest == 8'h00) else begin
                    $display("CHECK FAILED at %0t ns: result header %h dest %h",
                             $time, ctrl_tx.header, ctrl_tx.dest);
                    mon_errors++;
                end
            end
            // a stalled word must hold until it is taken
            if (out_stalled) begin
                assert (out_valid && out_data == stalled_word) else begin
                    $display("CHECK FAILED at %0t ns: stalled word %h changed to %h",
                             $time, stalled_word, out_data);
                    mon_errors++;
                end
            end
            assert (!ctrl_stalled || ctrl_tx_valid) else begin
                $display("ERROR at %0t ns: result message dropped before it was taken", $time);
                mon_errors++;
            end
            out_stalled = out_valid && !out_ready;
            stalled_word = out_data;
            ctrl_stalled = ctrl_tx_valid && !ctrl_tx_ready;
        end
    end

    // called right after a rising edge
    task automatic send_command(input logic [7:0] header, input logic peel);
        ctrl_rx <= {header, 8'h00, 47'h0, peel};
        ctrl_rx_valid <= 1'b1;
        @(negedge clk);
        while (!ctrl_rx_ready) @(negedge clk);
        @(posedge clk);
        ctrl_rx_valid <= 1'b0;
    endtask

    task automatic send_word(input stream_word_t word);
        in_data <= word;
        in_valid <= 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic run_decode(input row_t row);
        @(posedge clk);
        cur_row = row;
        send_command(header_decode_block, row.peel);
        for (int i = 0; i < int'(row.defect_count); i++) begin
            send_word({28'h0, row.defect_list[i]});
        end
        send_word(end_marker);
        in_valid <= 1'b0;
        if (row.peel) begin
            while (!(end_seen && ctrl_seen)) @(posedge clk);
            assert (ctrl_cycles == header_counts[15:0] && ctrl_cycles != 16'd0) else begin
                $display("CHECK FAILED at %0t ns: result cycles %0d, header cycles %0d",
                         $time, ctrl_cycles, header_counts[15:0]);
                seq_errors++;
            end
        end else begin
            while (stage != stage_idle) @(posedge clk);
            repeat (10) @(posedge clk);
        end
        assert (meas_count == grid_u) else begin
            $display("CHECK FAILED at %0t ns: %0d measurement rounds, expected %0d",
                     $time, meas_count, grid_u);
            seq_errors++;
        end
    endtask

    initial begin
        // defect count, defect list, odd merges, peel, corrections of rounds 2, 1, 0
        rows[0] = {3'd3, 24'h00_0930, 8'd1, 1'b1, 11'h401, 11'h000, 11'h005};
        rows[1] = {3'd0, 24'h00_0000, 8'd0, 1'b1, 11'h000, 11'h000, 11'h000};
        rows[2] = {3'd5, 24'h0a_7422, 8'd2, 1'b0, 11'h7ff, 11'h7ff, 11'h7ff};
        rows[3] = {3'd4, 24'h00_b865, 8'd3, 1'b1, 11'h000, 11'h080, 11'h7ff};
        rows[4] = {3'd2, 24'h00_00b1, 8'd0, 1'b1, 11'h400, 11'h013, 11'h000};
        cur_row = rows[0];
        ctrl_rx = '0;
        ctrl_rx_valid = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        @(negedge clk);
        while (reset) @(negedge clk);
        assert (!ctrl_tx_valid && !out_valid && !in_ready && !measurements.valid &&
                stage == stage_idle && ctrl_rx_ready) else begin
            $display("ERROR at %0t ns: outputs not in their idle state after reset", $time);
            seq_errors++;
        end
        // unknown header is dropped
        @(posedge clk);
        send_command(8'h55, 1'b1);
        @(negedge clk);
        assert (stage == stage_idle) else begin
            $display("ERROR at %0t ns: unknown command started a decode", $time);
            seq_errors++;
        end
        for (int i = 0; i < num_rows; i++) begin
            run_decode(rows[i]);
        end
        $display("errors: %0d from output checks, %0d from sequence checks",
                 mon_errors, seq_errors);
        if (mon_errors + seq_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (num_rows * cycles_per_row) @(posedge clk);
        $display("ERROR: timeout, decodes not finished after %0d cycles",
                 num_rows * cycles_per_row);
        $display("errors: %0d from output checks, %0d from sequence checks",
                 mon_errors, seq_errors);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: decoder_ctrl.f
rtl/decoder_ctrl_pkg.sv
rtl/stage_controller.sv
rtl/measurement_loader.sv
rtl/latency_counters.sv
rtl/correction_fifo.sv
rtl/correction_serializer.sv
rtl/decoder_ctrl_top.sv
testbench/tb_clock_gen.sv
testbench/tb_decoder_ctrl.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_decoder_ctrl \
    -f decoder_ctrl.f \
    --Mdir obj_dir -o tb_decoder_ctrl

./obj_dir/tb_decoder_ctrl > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
    exit 1
fi
